/* source/apb_sys_settings.svh */
`ifndef APB_SYS_SETTINGS_SVH
`define APB_SYS_SETTINGS_SVH

// boot vector width, 32 or 64
`define XLEN 32

// slot number comes from paddr[15:12]
`define SLOT_CFG   4'd0
`define SLOT_TIMER 4'd1
`define SLOT_GPIO  4'd2

`define CFGREG_RSTN    12'h000
`define CFGREG_BOOTVEC 12'h004
`define CFGREG_RSVREG0 12'h008
`define CFGREG_RSVREG1 12'h00C

`define MTIMER_CTRL    12'h000
`define MTIMER_TIME_LO 12'h004
`define MTIMER_TIME_HI 12'h008
`define MTIMER_CMP_LO  12'h00C
`define MTIMER_CMP_HI  12'h010

`define GPIO_OUT 12'h000
`define GPIO_OE  12'h004
`define GPIO_IN  12'h008

`define GPIO_WIDTH 32

`endif

/* source/apb_sys_pkg.sv */
`include "apb_sys_settings.svh"

package apb_sys_pkg;

    typedef logic [31:0]        apb_data_t;
    typedef logic [11:0]        reg_off_t;
    typedef logic [3:0]         strb_t;
    typedef logic [`XLEN-1:0]   xlen_t;

    // one request per slot, setup is only high for the addressed slot
    typedef struct packed {
        logic      setup;
        logic      write;
        reg_off_t  off;
        apb_data_t wdata;
        strb_t     strb;
    } apb_req_t;

    // read word captured by the slave during the setup phase
    typedef struct packed {
        apb_data_t rdata;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_SETUP,
        DEC_ACCESS
    } dec_state_e;

endpackage

/* source/apb_decoder.sv */
`timescale 1ns/1ps
`include "apb_sys_settings.svh"

module apb_decoder (
    input  logic                  pclk,
    input  logic                  presetn,
    input  logic                  psel,
    input  logic                  penable,
    input  apb_sys_pkg::apb_data_t paddr,
    input  logic                  pwrite,
    input  apb_sys_pkg::strb_t    pstrb,
    input  apb_sys_pkg::apb_data_t pwdata,
    input  apb_sys_pkg::apb_rsp_t cfg_rsp,
    input  apb_sys_pkg::apb_rsp_t timer_rsp,
    input  apb_sys_pkg::apb_rsp_t gpio_rsp,
    output apb_sys_pkg::apb_req_t cfg_req,
    output apb_sys_pkg::apb_req_t timer_req,
    output apb_sys_pkg::apb_req_t gpio_req,
    output apb_sys_pkg::apb_data_t prdata,
    output logic                  pslverr
);

    apb_sys_pkg::dec_state_e state_q;
    apb_sys_pkg::dec_state_e state_d;
    apb_sys_pkg::apb_req_t   req_base;
    apb_sys_pkg::apb_data_t  rdata_mux;

    logic [3:0] slot;
    logic [3:0] slot_q;
    logic       unmapped;
    logic       unmapped_q;
    logic       setup_cyc;
    logic       access_cyc;

    assign slot      = paddr[15:12];
    assign setup_cyc = psel && !penable;
    assign unmapped  = (slot != `SLOT_CFG) && (slot != `SLOT_TIMER) && (slot != `SLOT_GPIO);

    // an access only counts when it directly follows a setup cycle
    assign access_cyc = (state_q == apb_sys_pkg::DEC_SETUP) && psel && penable;

    always_comb begin
        state_d = apb_sys_pkg::DEC_IDLE;
        case (state_q)
            apb_sys_pkg::DEC_SETUP: begin
                if (psel && penable)
                    state_d = apb_sys_pkg::DEC_ACCESS;
                else if (setup_cyc)
                    state_d = apb_sys_pkg::DEC_SETUP;
            end
            default: begin
                if (setup_cyc)
                    state_d = apb_sys_pkg::DEC_SETUP;  // back to back transfers land here
            end
        endcase
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            state_q    <= apb_sys_pkg::DEC_IDLE;
            slot_q     <= 4'd0;
            unmapped_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (setup_cyc) begin
                slot_q     <= slot;
                unmapped_q <= unmapped;
            end
        end
    end

    assign req_base.setup = 1'b0;
    assign req_base.write = pwrite;
    assign req_base.off   = paddr[11:0];
    assign req_base.wdata = pwdata;
    assign req_base.strb  = pstrb;

    always_comb begin
        cfg_req         = req_base;
        timer_req       = req_base;
        gpio_req        = req_base;
        cfg_req.setup   = setup_cyc && (slot == `SLOT_CFG);
        timer_req.setup = setup_cyc && (slot == `SLOT_TIMER);
        gpio_req.setup  = setup_cyc && (slot == `SLOT_GPIO);
    end

    always_comb begin
        case (slot_q)
            `SLOT_CFG:   rdata_mux = cfg_rsp.rdata;
            `SLOT_TIMER: rdata_mux = timer_rsp.rdata;
            `SLOT_GPIO:  rdata_mux = gpio_rsp.rdata;
            default:     rdata_mux = '0;
        endcase
    end

    assign prdata  = (access_cyc && !unmapped_q) ? rdata_mux : '0;
    assign pslverr = access_cyc && unmapped_q;

endmodule

/* source/cfgreg.sv */
`timescale 1ns/1ps
`include "apb_sys_settings.svh"

module cfgreg (
    input  logic                  pclk,
    input  logic                  presetn,
    input  apb_sys_pkg::apb_req_t req,
    output apb_sys_pkg::apb_rsp_t rsp,
    output apb_sys_pkg::xlen_t    core_bootvec,
    output logic                  core_rstn
);

    apb_sys_pkg::apb_data_t rsv_reg0;
    apb_sys_pkg::apb_data_t rsv_reg1;
    apb_sys_pkg::apb_data_t rdata_d;
    logic                   wr;

    // writes land on the setup edge, one cycle before the access phase
    assign wr = req.setup && req.write;

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            core_rstn <= 1'b0;  // core held in reset until software releases it
        end else if (wr && req.off == `CFGREG_RSTN) begin
            core_rstn <= req.wdata[0];
        end
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            core_bootvec <= '0;
        end else if (wr && req.off == `CFGREG_BOOTVEC) begin
            core_bootvec <= apb_sys_pkg::xlen_t'(req.wdata);
        end
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            rsv_reg0 <= '0;
            rsv_reg1 <= '0;
        end else if (wr) begin
            if (req.off == `CFGREG_RSVREG0)
                rsv_reg0 <= req.wdata;
            if (req.off == `CFGREG_RSVREG1)
                rsv_reg1 <= req.wdata;
        end
    end

    always_comb begin
        case (req.off)
            `CFGREG_RSTN:    rdata_d = {31'b0, core_rstn};
            `CFGREG_BOOTVEC: rdata_d = apb_sys_pkg::apb_data_t'(core_bootvec);
            `CFGREG_RSVREG0: rdata_d = rsv_reg0;
            `CFGREG_RSVREG1: rdata_d = rsv_reg1;
            default:         rdata_d = '0;  // holes in the map read as zero
        endcase
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            rsp.rdata <= '0;
        end else if (req.setup) begin
            rsp.rdata <= rdata_d;
        end
    end

endmodule

/* source/mtimer.sv */
`timescale 1ns/1ps
`include "apb_sys_settings.svh"

module mtimer (
    input  logic                  pclk,
    input  logic                  presetn,
    input  apb_sys_pkg::apb_req_t req,
    output apb_sys_pkg::apb_rsp_t rsp,
    output logic                  timer_irq
);

    logic [63:0]            mtime;
    logic [63:0]            mtimecmp;
    logic                   timer_en;
    logic                   wr;
    logic                   wr_time_lo;
    logic                   wr_time_hi;
    apb_sys_pkg::apb_data_t rdata_d;

    assign wr         = req.setup && req.write;
    assign wr_time_lo = wr && (req.off == `MTIMER_TIME_LO);
    assign wr_time_hi = wr && (req.off == `MTIMER_TIME_HI);

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            timer_en <= 1'b0;
        end else if (wr && req.off == `MTIMER_CTRL) begin
            timer_en <= req.wdata[0];
        end
    end

    // a software write wins over the increment, the other half holds its value
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            mtime <= '0;
        end else if (wr_time_lo) begin
            mtime[31:0] <= req.wdata;
        end else if (wr_time_hi) begin
            mtime[63:32] <= req.wdata;
        end else if (timer_en) begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            mtimecmp <= '1;  // all ones keeps the interrupt quiet out of reset
        end else if (wr) begin
            if (req.off == `MTIMER_CMP_LO)
                mtimecmp[31:0] <= req.wdata;
            if (req.off == `MTIMER_CMP_HI)
                mtimecmp[63:32] <= req.wdata;
        end
    end

    // level interrupt, stays high until the compare value moves past mtime
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    always_comb begin
        case (req.off)
            `MTIMER_CTRL:    rdata_d = {31'b0, timer_en};
            `MTIMER_TIME_LO: rdata_d = mtime[31:0];
            `MTIMER_TIME_HI: rdata_d = mtime[63:32];
            `MTIMER_CMP_LO:  rdata_d = mtimecmp[31:0];
            `MTIMER_CMP_HI:  rdata_d = mtimecmp[63:32];
            default:         rdata_d = '0;
        endcase
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            rsp.rdata <= '0;
        end else if (req.setup) begin
            rsp.rdata <= rdata_d;
        end
    end

endmodule

/* source/gpio.sv */
`timescale 1ns/1ps
`include "apb_sys_settings.svh"

module gpio (
    input  logic                    pclk,
    input  logic                    presetn,
    input  apb_sys_pkg::apb_req_t   req,
    input  logic [`GPIO_WIDTH-1:0]  gpio_in,
    output apb_sys_pkg::apb_rsp_t   rsp,
    output logic [`GPIO_WIDTH-1:0]  gpio_out,
    output logic [`GPIO_WIDTH-1:0]  gpio_oe
);

    logic [`GPIO_WIDTH-1:0] in_meta;
    logic [`GPIO_WIDTH-1:0] in_sync;
    logic                   wr;
    apb_sys_pkg::apb_data_t rdata_d;

    assign wr = req.setup && req.write;

    // each set strobe bit updates one byte lane
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            gpio_out <= '0;
            gpio_oe  <= '0;
        end else if (wr) begin
            for (int i = 0; i < `GPIO_WIDTH / 8; i++) begin
                if (req.strb[i] && req.off == `GPIO_OUT)
                    gpio_out[i*8 +: 8] <= req.wdata[i*8 +: 8];
                if (req.strb[i] && req.off == `GPIO_OE)
                    gpio_oe[i*8 +: 8] <= req.wdata[i*8 +: 8];
            end
        end
    end

    // pins are asynchronous to pclk
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    always_comb begin
        case (req.off)
            `GPIO_OUT: rdata_d = apb_sys_pkg::apb_data_t'(gpio_out);
            `GPIO_OE:  rdata_d = apb_sys_pkg::apb_data_t'(gpio_oe);
            `GPIO_IN:  rdata_d = apb_sys_pkg::apb_data_t'(in_sync);  // read only
            default:   rdata_d = '0;
        endcase
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            rsp.rdata <= '0;
        end else if (req.setup) begin
            rsp.rdata <= rdata_d;
        end
    end

endmodule

/* source/apb_periph_top.sv */
`timescale 1ns/1ps
`include "apb_sys_settings.svh"

module apb_periph_top (
    input  logic                    pclk,
    input  logic                    presetn,
    input  logic                    psel,
    input  logic                    penable,
    input  apb_sys_pkg::apb_data_t  paddr,
    input  logic                    pwrite,
    input  apb_sys_pkg::strb_t      pstrb,
    input  apb_sys_pkg::apb_data_t  pwdata,
    output apb_sys_pkg::apb_data_t  prdata,
    output logic                    pslverr,
    output logic                    pready,

    output apb_sys_pkg::xlen_t      core_bootvec,
    output logic                    core_rstn,

    output logic                    timer_irq,

    input  logic [`GPIO_WIDTH-1:0]  gpio_in,
    output logic [`GPIO_WIDTH-1:0]  gpio_out,
    output logic [`GPIO_WIDTH-1:0]  gpio_oe
);

    apb_sys_pkg::apb_req_t cfg_req;
    apb_sys_pkg::apb_req_t timer_req;
    apb_sys_pkg::apb_req_t gpio_req;
    apb_sys_pkg::apb_rsp_t cfg_rsp;
    apb_sys_pkg::apb_rsp_t timer_rsp;
    apb_sys_pkg::apb_rsp_t gpio_rsp;

    // every transfer completes in one access cycle
    assign pready = 1'b1;

    apb_decoder u_decoder (
        .pclk      (pclk),
        .presetn   (presetn),
        .psel      (psel),
        .penable   (penable),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .pstrb     (pstrb),
        .pwdata    (pwdata),
        .cfg_rsp   (cfg_rsp),
        .timer_rsp (timer_rsp),
        .gpio_rsp  (gpio_rsp),
        .cfg_req   (cfg_req),
        .timer_req (timer_req),
        .gpio_req  (gpio_req),
        .prdata    (prdata),
        .pslverr   (pslverr)
    );

    cfgreg u_cfgreg (
        .pclk         (pclk),
        .presetn      (presetn),
        .req          (cfg_req),
        .rsp          (cfg_rsp),
        .core_bootvec (core_bootvec),
        .core_rstn    (core_rstn)
    );

    mtimer u_mtimer (
        .pclk      (pclk),
        .presetn   (presetn),
        .req       (timer_req),
        .rsp       (timer_rsp),
        .timer_irq (timer_irq)
    );

    gpio u_gpio (
        .pclk     (pclk),
        .presetn  (presetn),
        .req      (gpio_req),
        .gpio_in  (gpio_in),
        .rsp      (gpio_rsp),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

endmodule

/* verif/tb_apb_periph.sv */
`timescale 1ns/1ps
`include "apb_sys_settings.svh"

module tb_apb_periph;

    localparam int ACCESS_TIMEOUT = 16;
    localparam int IRQ_DELAY      = 10;  // compare value used by the timer test

    logic                   pclk;
    logic                   presetn;
    logic                   psel;
    logic                   penable;
    apb_sys_pkg::apb_data_t paddr;
    logic                   pwrite;
    apb_sys_pkg::strb_t     pstrb;
    apb_sys_pkg::apb_data_t pwdata;
    apb_sys_pkg::apb_data_t prdata;
    logic                   pslverr;
    logic                   pready;
    apb_sys_pkg::xlen_t     core_bootvec;
    logic                   core_rstn;
    logic                   timer_irq;
    logic [`GPIO_WIDTH-1:0] gpio_in;
    logic [`GPIO_WIDTH-1:0] gpio_out;
    logic [`GPIO_WIDTH-1:0] gpio_oe;

    string cur_test;
    int    check_fails;
    int    fails_at_open;
    int    tests_run;
    int    tests_failed;

    apb_periph_top uut (
        .pclk         (pclk),
        .presetn      (presetn),
        .psel         (psel),
        .penable      (penable),
        .paddr        (paddr),
        .pwrite       (pwrite),
        .pstrb        (pstrb),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .pready       (pready),
        .core_bootvec (core_bootvec),
        .core_rstn    (core_rstn),
        .timer_irq    (timer_irq),
        .gpio_in      (gpio_in),
        .gpio_out     (gpio_out),
        .gpio_oe      (gpio_oe)
    );

    always #50 pclk = ~pclk;

    function automatic apb_sys_pkg::apb_data_t make_addr(input logic [3:0] slot,
                                                         input apb_sys_pkg::reg_off_t off);
        return {16'h0000, slot, off};  // slot sits in paddr[15:12]
    endfunction

    task automatic compare_value(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s: %s expected 0x%0h actual 0x%0h", cur_test, what,
                     expected, actual);
            check_fails++;
        end
    endtask

    task automatic confirm(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            $display("ERROR %s: %s", cur_test, msg);
            check_fails++;
        end
    endtask

    task automatic open_test(input string name);
        cur_test      = name;
        fails_at_open = check_fails;
        tests_run++;
    endtask

    task automatic close_test();
        if (check_fails != fails_at_open)
            tests_failed++;
        $display("%s: %s", cur_test, (check_fails == fails_at_open) ? "passed" : "failed");
    endtask

    // one setup cycle and one access cycle, sampled in the middle of the access cycle
    task automatic apb_transfer(input logic write, input apb_sys_pkg::apb_data_t addr,
                                input apb_sys_pkg::apb_data_t wdata,
                                input apb_sys_pkg::strb_t strb,
                                output apb_sys_pkg::apb_data_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge pclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        pstrb   <= strb;
        @(posedge pclk);
        penable <= 1'b1;
        @(negedge pclk);
        while (pready !== 1'b1 && waited < ACCESS_TIMEOUT) begin
            @(negedge pclk);
            waited++;
        end
        confirm(pready, "pready stayed low past the access timeout");
        rdata = prdata;
        err   = pslverr;
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        @(negedge pclk);
    endtask

    task automatic apb_write(input apb_sys_pkg::apb_data_t addr, input apb_sys_pkg::apb_data_t wdata,
                             input apb_sys_pkg::strb_t strb,
                             output apb_sys_pkg::apb_data_t rdata, output logic err);
        apb_transfer(1'b1, addr, wdata, strb, rdata, err);
    endtask

    task automatic apb_read(input apb_sys_pkg::apb_data_t addr,
                            output apb_sys_pkg::apb_data_t rdata, output logic err);
        apb_transfer(1'b0, addr, 32'h0, 4'h0, rdata, err);
    endtask

    task automatic read_and_compare(input string what, input apb_sys_pkg::apb_data_t addr,
                                    input apb_sys_pkg::apb_data_t expected);
        apb_sys_pkg::apb_data_t rdata;
        logic                   err;
        apb_read(addr, rdata, err);
        compare_value(what, 64'(expected), 64'(rdata));
        compare_value({what, " pslverr"}, 64'd0, 64'(err));
    endtask

    task automatic reset_values();
        open_test("reset_values");
        compare_value("core_rstn", 64'd0, 64'(core_rstn));
        compare_value("core_bootvec", 64'd0, 64'(core_bootvec));
        compare_value("timer_irq", 64'd0, 64'(timer_irq));
        compare_value("gpio_out", 64'd0, 64'(gpio_out));
        compare_value("gpio_oe", 64'd0, 64'(gpio_oe));
        read_and_compare("BOOTVEC", make_addr(`SLOT_CFG, `CFGREG_BOOTVEC), 32'h0);
        close_test();
    endtask

    task automatic config_regs();
        apb_sys_pkg::apb_data_t w_boot;
        apb_sys_pkg::apb_data_t w_rsv0;
        apb_sys_pkg::apb_data_t w_rsv1;
        apb_sys_pkg::apb_data_t rdata;
        logic                   err;
        open_test("config_regs");
        w_boot = $urandom();
        w_rsv0 = $urandom();
        w_rsv1 = $urandom();
        apb_write(make_addr(`SLOT_CFG, `CFGREG_BOOTVEC), w_boot, 4'hF, rdata, err);
        apb_write(make_addr(`SLOT_CFG, `CFGREG_RSVREG0), w_rsv0, 4'hF, rdata, err);
        apb_write(make_addr(`SLOT_CFG, `CFGREG_RSVREG1), w_rsv1, 4'hF, rdata, err);
        read_and_compare("BOOTVEC", make_addr(`SLOT_CFG, `CFGREG_BOOTVEC), w_boot);
        read_and_compare("RSVREG0", make_addr(`SLOT_CFG, `CFGREG_RSVREG0), w_rsv0);
        read_and_compare("RSVREG1", make_addr(`SLOT_CFG, `CFGREG_RSVREG1), w_rsv1);
        compare_value("core_bootvec", 64'(w_boot), 64'(core_bootvec));
        apb_write(make_addr(`SLOT_CFG, `CFGREG_RSTN), 32'h1, 4'hF, rdata, err);
        compare_value("core_rstn", 64'd1, 64'(core_rstn));
        read_and_compare("RSTN", make_addr(`SLOT_CFG, `CFGREG_RSTN), 32'h1);
        read_and_compare("unused offset", make_addr(`SLOT_CFG, 12'h010), 32'h0);
        close_test();
    endtask

    task automatic gpio_strobes();
        apb_sys_pkg::apb_data_t w_full;
        apb_sys_pkg::apb_data_t w_part;
        apb_sys_pkg::apb_data_t w_oe;
        apb_sys_pkg::apb_data_t expected;
        apb_sys_pkg::apb_data_t pin_val;
        apb_sys_pkg::apb_data_t rdata;
        logic                   err;
        open_test("gpio_strobes");
        w_full = $urandom();
        w_part = $urandom();
        w_oe   = $urandom();
        apb_write(make_addr(`SLOT_GPIO, `GPIO_OUT), w_full, 4'hF, rdata, err);
        compare_value("gpio_out after full write", 64'(w_full), 64'(gpio_out));
        apb_write(make_addr(`SLOT_GPIO, `GPIO_OUT), w_part, 4'b0010, rdata, err);
        expected = {w_full[31:16], w_part[15:8], w_full[7:0]};  // only byte 1 replaced
        compare_value("gpio_out after byte 1 write", 64'(expected), 64'(gpio_out));
        read_and_compare("GPIO_OUT", make_addr(`SLOT_GPIO, `GPIO_OUT), expected);
        apb_write(make_addr(`SLOT_GPIO, `GPIO_OE), w_oe, 4'hF, rdata, err);
        compare_value("gpio_oe after full write", 64'(w_oe), 64'(gpio_oe));
        read_and_compare("GPIO_OE", make_addr(`SLOT_GPIO, `GPIO_OE), w_oe);
        pin_val = $urandom();
        @(posedge pclk);
        gpio_in <= pin_val;
        repeat (4) @(posedge pclk);
        read_and_compare("GPIO_IN", make_addr(`SLOT_GPIO, `GPIO_IN), pin_val);
        close_test();
    endtask

    task automatic timer_interrupt();
        apb_sys_pkg::apb_data_t rdata;
        logic                   err;
        int                     waited;
        open_test("timer_interrupt");
        apb_write(make_addr(`SLOT_TIMER, `MTIMER_CTRL), 32'h0, 4'hF, rdata, err);
        apb_write(make_addr(`SLOT_TIMER, `MTIMER_TIME_LO), 32'h0, 4'hF, rdata, err);
        apb_write(make_addr(`SLOT_TIMER, `MTIMER_TIME_HI), 32'h0, 4'hF, rdata, err);
        apb_write(make_addr(`SLOT_TIMER, `MTIMER_CMP_HI), 32'h0, 4'hF, rdata, err);
        apb_write(make_addr(`SLOT_TIMER, `MTIMER_CMP_LO), 32'(IRQ_DELAY), 4'hF, rdata, err);
        confirm(timer_irq === 1'b0, "timer_irq went high before the timer was enabled");
        apb_write(make_addr(`SLOT_TIMER, `MTIMER_CTRL), 32'h1, 4'hF, rdata, err);
        waited = 0;
        while (timer_irq !== 1'b1 && waited < IRQ_DELAY + 4) begin
            @(negedge pclk);
            waited++;
        end
        confirm(timer_irq, "timer_irq did not rise within the compare value plus 4 cycles");
        apb_read(make_addr(`SLOT_TIMER, `MTIMER_TIME_LO), rdata, err);
        assert (rdata >= 32'(IRQ_DELAY)) else begin
            $display("MISMATCH %s: TIME_LO expected >= 0x%0h actual 0x%0h", cur_test,
                     IRQ_DELAY, rdata);
            check_fails++;
        end
        apb_write(make_addr(`SLOT_TIMER, `MTIMER_CMP_LO), 32'hFFFF_FFFF, 4'hF, rdata, err);
        apb_write(make_addr(`SLOT_TIMER, `MTIMER_CMP_HI), 32'hFFFF_FFFF, 4'hF, rdata, err);
        waited = 0;
        while (timer_irq !== 1'b0 && waited < 4) begin
            @(negedge pclk);
            waited++;
        end
        confirm(timer_irq === 1'b0, "timer_irq stayed high after the compare value went to all ones");
        apb_write(make_addr(`SLOT_TIMER, `MTIMER_CTRL), 32'h0, 4'hF, rdata, err);
        close_test();
    endtask

    task automatic unmapped_slot();
        apb_sys_pkg::xlen_t     bootvec_before;
        logic                   rstn_before;
        logic [`GPIO_WIDTH-1:0] out_before;
        logic [`GPIO_WIDTH-1:0] oe_before;
        apb_sys_pkg::apb_data_t rsv0_before;
        apb_sys_pkg::apb_data_t time_lo_before;
        apb_sys_pkg::apb_data_t rdata;
        logic                   err;
        open_test("unmapped_slot");
        bootvec_before = core_bootvec;
        rstn_before    = core_rstn;
        out_before     = gpio_out;
        oe_before      = gpio_oe;
        apb_read(make_addr(`SLOT_CFG, `CFGREG_RSVREG0), rsv0_before, err);
        apb_read(make_addr(`SLOT_TIMER, `MTIMER_TIME_LO), time_lo_before, err);  // timer is stopped
        apb_read(make_addr(4'd3, 12'h000), rdata, err);
        compare_value("slot 3 read pslverr", 64'd1, 64'(err));
        compare_value("slot 3 read prdata", 64'd0, 64'(rdata));
        apb_write(make_addr(4'd3, `CFGREG_BOOTVEC), $urandom(), 4'hF, rdata, err);
        compare_value("slot 3 write pslverr", 64'd1, 64'(err));
        compare_value("slot 3 write prdata", 64'd0, 64'(rdata));
        compare_value("core_bootvec", 64'(bootvec_before), 64'(core_bootvec));
        compare_value("core_rstn", 64'(rstn_before), 64'(core_rstn));
        compare_value("gpio_out", 64'(out_before), 64'(gpio_out));
        compare_value("gpio_oe", 64'(oe_before), 64'(gpio_oe));
        read_and_compare("RSVREG0", make_addr(`SLOT_CFG, `CFGREG_RSVREG0), rsv0_before);
        read_and_compare("TIME_LO", make_addr(`SLOT_TIMER, `MTIMER_TIME_LO), time_lo_before);
        close_test();
    endtask

    initial begin
        pclk         = 1'b0;
        presetn      = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        paddr        = '0;
        pwrite       = 1'b0;
        pstrb        = '0;
        pwdata       = '0;
        gpio_in      = '0;
        check_fails  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'haa447e7b));
        repeat (8) @(posedge pclk);
        presetn <= 1'b1;
        @(negedge pclk);
        reset_values();
        config_regs();
        gpio_strobes();
        timer_interrupt();
        unmapped_slot();
        $display("tests run %0d, tests failed %0d, failed checks %0d", tests_run, tests_failed,
                 check_fails);
        if (check_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // last resort if something stalls outside the bounded loops
    initial begin
        repeat (20000) @(posedge pclk);
        $display("ERROR: simulation ran past the global cycle limit");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* flist.f */
+incdir+source
source/apb_sys_pkg.sv
source/apb_decoder.sv
source/cfgreg.sv
source/mtimer.sv
source/gpio.sv
source/apb_periph_top.sv
verif/tb_apb_periph.sv

/* run_sim.sh */
#!/bin/sh
# build and run the APB peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_apb_periph -f flist.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log

# the testbench prints the fail message on any failed check or timeout
grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }

echo "simulation passed"
exit 0
